//--- include/decode_opcodes.svh
`ifndef DECODE_OPCODES_SVH
`define DECODE_OPCODES_SVH

// 1RI20 major opcodes, instr[31:25]
`define EXE_LU12I_W   7'b0001010
`define EXE_PCADDI    7'b0001100
`define EXE_PCADDU12I 7'b0001110

// 2RI12 major opcodes, instr[31:22]

// alu immediate group
`define EXE_SLTI      10'b0000001000
`define EXE_SLTUI     10'b0000001001
`define EXE_ADDI_W    10'b0000001010
`define EXE_ANDI      10'b0000001101
`define EXE_ORI       10'b0000001110
`define EXE_XORI      10'b0000001111

// word load and store
`define EXE_LD_W      10'b0010100010
`define EXE_ST_W      10'b0010100110

`endif

//--- rtl/decode_pkg.sv
package decode_pkg;

    // operation handed to the alu
    typedef enum logic [3:0] {
        ALU_NOP   = 4'd0,
        ALU_LUI   = 4'd1,
        ALU_PCADD = 4'd2,
        ALU_ADD   = 4'd3,
        ALU_SLT   = 4'd4,
        ALU_SLTU  = 4'd5,
        ALU_AND   = 4'd6,
        ALU_OR    = 4'd7,
        ALU_XOR   = 4'd8
    } aluop_e;

    // result class, picks the writeback source
    typedef enum logic [2:0] {
        SEL_NOP   = 3'd0,
        SEL_MOVE  = 3'd1,
        SEL_ARITH = 3'd2,
        SEL_LOGIC = 3'd3,
        SEL_MEM   = 3'd4
    } alusel_e;

    // {op7, imm20, rd}
    typedef struct packed {
        logic [6:0]  op7;
        logic [19:0] imm20;
        logic [4:0]  rd;
    } ri20_fmt_t;

    // {op10, imm12, rj, rd}
    typedef struct packed {
        logic [9:0]  op10;
        logic [11:0] imm12;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } ri12_fmt_t;

    // same 32-bit word, read through either format
    typedef union packed {
        ri20_fmt_t ri20;
        ri12_fmt_t ri12;
    } instr_word_u;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        aluop_e      aluop;
        alusel_e     alusel;
        logic        use_imm;
        logic [31:0] imm;
        logic        reg_read_valid;
        logic [4:0]  rj;
        logic        reg_write_valid;
        logic [4:0]  rd;
        logic        mem_load;
        logic        mem_store;
    } decode_result_t;

endpackage

//--- rtl/decode_if.sv
`timescale 1ns/1ps

// one lane's result path into the collector
interface decode_if import decode_pkg::*; ();

    logic           res_valid;
    decode_result_t res;

    // one pulse per entry popped from this lane's collector fifo
    logic           credit_ret;

    modport lane_mp (
        output res_valid,
        output res
    );

    modport coll_mp (
        input  res_valid,
        input  res,
        output credit_ret
    );

    // dispatcher only watches the returned credits
    modport disp_mp (
        input  credit_ret
    );

endinterface

//--- rtl/decoder_1ri20.sv
`timescale 1ns/1ps
`include "decode_opcodes.svh"

module decoder_1ri20 import decode_pkg::*; (
    input  instr_word_u    instr_i,
    output decode_result_t result_o
);

    logic [19:0] imm20;
    logic        hit;

    assign imm20 = instr_i.ri20.imm20;

    always_comb begin
        result_o = '0;
        hit      = 1'b1;
        case (instr_i.ri20.op7)
            `EXE_LU12I_W: begin
                result_o.aluop = ALU_LUI;
                result_o.imm   = {imm20, 12'b0};
            end
            `EXE_PCADDI: begin
                // word offset, sign extended
                result_o.aluop = ALU_PCADD;
                result_o.imm   = {{10{imm20[19]}}, imm20, 2'b0};
            end
            `EXE_PCADDU12I: begin
                result_o.aluop = ALU_PCADD;
                result_o.imm   = {imm20, 12'b0};
            end
            default: begin
                hit = 1'b0;
            end
        endcase

        // shared by all three: move class, write rd, no source reg
        if (hit) begin
            result_o.valid           = 1'b1;
            result_o.alusel          = SEL_MOVE;
            result_o.use_imm         = 1'b1;
            result_o.reg_write_valid = 1'b1;
            result_o.rd              = instr_i.ri20.rd;
        end
    end

endmodule

//--- rtl/decoder_2ri12.sv
`timescale 1ns/1ps
`include "decode_opcodes.svh"

module decoder_2ri12 import decode_pkg::*; (
    input  instr_word_u    instr_i,
    output decode_result_t result_o
);

    logic [11:0] imm12;
    logic        hit;
    logic        sext;
    logic        is_store;
    logic        is_load;
    aluop_e      aluop;
    alusel_e     alusel;

    assign imm12 = instr_i.ri12.imm12;

    always_comb begin
        hit      = 1'b1;
        sext     = 1'b1;
        is_store = 1'b0;
        is_load  = 1'b0;
        aluop    = ALU_NOP;
        alusel   = SEL_NOP;
        case (instr_i.ri12.op10)
            `EXE_ADDI_W: begin
                aluop  = ALU_ADD;
                alusel = SEL_ARITH;
            end
            `EXE_SLTI: begin
                aluop  = ALU_SLT;
                alusel = SEL_ARITH;
            end
            `EXE_SLTUI: begin
                // compare is unsigned, the immediate is still sign extended
                aluop  = ALU_SLTU;
                alusel = SEL_ARITH;
            end
            `EXE_ANDI: begin
                aluop  = ALU_AND;
                alusel = SEL_LOGIC;
                sext   = 1'b0;
            end
            `EXE_ORI: begin
                aluop  = ALU_OR;
                alusel = SEL_LOGIC;
                sext   = 1'b0;
            end
            `EXE_XORI: begin
                aluop  = ALU_XOR;
                alusel = SEL_LOGIC;
                sext   = 1'b0;
            end
            `EXE_LD_W: begin
                // address = rj + offset
                aluop   = ALU_ADD;
                alusel  = SEL_MEM;
                is_load = 1'b1;
            end
            `EXE_ST_W: begin
                aluop    = ALU_ADD;
                alusel   = SEL_MEM;
                is_store = 1'b1;
            end
            default: begin
                hit = 1'b0;
            end
        endcase

        result_o = '0;
        if (hit) begin
            result_o.valid           = 1'b1;
            result_o.aluop           = aluop;
            result_o.alusel          = alusel;
            result_o.use_imm         = 1'b1;
            result_o.imm             = sext ? {{20{imm12[11]}}, imm12} : {20'b0, imm12};
            result_o.reg_read_valid  = 1'b1;
            result_o.rj              = instr_i.ri12.rj;
            // for st.w rd names the store data, nothing is written back
            result_o.reg_write_valid = !is_store;
            result_o.rd              = instr_i.ri12.rd;
            result_o.mem_load        = is_load;
            result_o.mem_store       = is_store;
        end
    end

endmodule

//--- rtl/decode_lane.sv
`timescale 1ns/1ps

module decode_lane import decode_pkg::*; (
    input  logic        clk,
    input  logic        rst_i,
    input  logic        valid_i,
    input  instr_word_u instr_i,
    input  logic [31:0] pc_i,
    decode_if.lane_mp   res
);

    decode_result_t ri20_res;
    decode_result_t ri12_res;
    decode_result_t merged;

    decoder_1ri20 u_dec_1ri20 (
        .instr_i  (instr_i),
        .result_o (ri20_res)
    );

    decoder_2ri12 u_dec_2ri12 (
        .instr_i  (instr_i),
        .result_o (ri12_res)
    );

    // opcode spaces do not overlap, at most one side hits
    always_comb begin
        if (ri20_res.valid) begin
            merged = ri20_res;
        end else if (ri12_res.valid) begin
            merged = ri12_res;
        end else begin
            merged = '0;
        end
        // pc travels even with an illegal opcode
        merged.pc = pc_i;
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            res.res_valid <= 1'b0;
        end else begin
            res.res_valid <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (valid_i) begin
            res.res <= merged;
        end
    end

endmodule

//--- rtl/instr_dispatcher.sv
`timescale 1ns/1ps

module instr_dispatcher #(
    parameter int LANE_NUM        = 2,
    parameter int LANE_FIFO_DEPTH = 2,
    parameter int IN_DEPTH        = 4
) (
    input  logic                       clk,
    input  logic                       rst_i,
    input  logic                       in_valid_i,
    input  logic [31:0]                in_instr_i,
    input  logic [31:0]                in_pc_i,
    output logic                       in_credit_o,
    output logic [LANE_NUM-1:0]        lane_valid_o,
    output logic [LANE_NUM-1:0][31:0]  lane_instr_o,
    output logic [LANE_NUM-1:0][31:0]  lane_pc_o,
    decode_if.disp_mp                  crd [LANE_NUM]
);

    localparam int PW = (IN_DEPTH > 1) ? $clog2(IN_DEPTH) : 1;
    localparam int CW = $clog2(IN_DEPTH + 1);
    localparam int LW = (LANE_NUM > 1) ? $clog2(LANE_NUM) : 1;
    localparam int KW = $clog2(LANE_FIFO_DEPTH + 1);

    logic [31:0]         fifo_instr [IN_DEPTH];
    logic [31:0]         fifo_pc [IN_DEPTH];
    logic [PW-1:0]       wr_ptr;
    logic [PW-1:0]       rd_ptr;
    logic [CW-1:0]       count;
    logic [LW-1:0]       rr_ptr;
    logic [KW-1:0]       lane_cnt [LANE_NUM];
    logic [LANE_NUM-1:0] credit_ret;
    logic                pop;

    for (genvar i = 0; i < LANE_NUM; i++) begin : g_crd
        assign credit_ret[i] = crd[i].credit_ret;
    end

    // head goes out only when the next lane in turn has room
    assign pop         = (count != '0) && (lane_cnt[rr_ptr] != '0);
    assign in_credit_o = pop;

    always_comb begin
        for (int l = 0; l < LANE_NUM; l++) begin
            lane_valid_o[l] = pop && (rr_ptr == LW'(l));
            lane_instr_o[l] = fifo_instr[rd_ptr];
            lane_pc_o[l]    = fifo_pc[rd_ptr];
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid_i) begin
            fifo_instr[wr_ptr] <= in_instr_i;
            fifo_pc[wr_ptr]    <= in_pc_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            rr_ptr <= '0;
        end else begin
            // upstream holds a credit for every push, so no full check
            if (in_valid_i) begin
                wr_ptr <= (wr_ptr == PW'(IN_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PW'(IN_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
                rr_ptr <= (rr_ptr == LW'(LANE_NUM - 1)) ? '0 : rr_ptr + 1'b1;
            end
            count <= count + CW'(in_valid_i) - CW'(pop);
        end
    end

    // one credit per free collector slot of each lane
    always_ff @(posedge clk) begin
        for (int l = 0; l < LANE_NUM; l++) begin
            if (rst_i) begin
                lane_cnt[l] <= KW'(LANE_FIFO_DEPTH);
            end else begin
                lane_cnt[l] <= lane_cnt[l] - KW'(lane_valid_o[l]) + KW'(credit_ret[l]);
            end
        end
    end

endmodule

//--- rtl/decode_collector.sv
`timescale 1ns/1ps

module decode_collector import decode_pkg::*; #(
    parameter int LANE_NUM        = 2,
    parameter int LANE_FIFO_DEPTH = 2,
    parameter int OUT_CREDITS     = 4
) (
    input  logic           clk,
    input  logic           rst_i,
    decode_if.coll_mp      res [LANE_NUM],
    input  logic           out_credit_i,
    output logic           out_valid_o,
    output decode_result_t out_result_o
);

    localparam int PW = (LANE_FIFO_DEPTH > 1) ? $clog2(LANE_FIFO_DEPTH) : 1;
    localparam int CW = $clog2(LANE_FIFO_DEPTH + 1);
    localparam int LW = (LANE_NUM > 1) ? $clog2(LANE_NUM) : 1;
    localparam int OW = $clog2(OUT_CREDITS + 1);

    decode_result_t      mem [LANE_NUM][LANE_FIFO_DEPTH];
    decode_result_t      push_data [LANE_NUM];
    logic [PW-1:0]       wr_ptr [LANE_NUM];
    logic [PW-1:0]       rd_ptr [LANE_NUM];
    logic [CW-1:0]       count [LANE_NUM];
    logic [LANE_NUM-1:0] push;
    logic [LANE_NUM-1:0] pop;
    logic [LW-1:0]       rr_ptr;
    logic [OW-1:0]       out_cnt;

    for (genvar i = 0; i < LANE_NUM; i++) begin : g_lane_port
        assign push[i]           = res[i].res_valid;
        assign push_data[i]      = res[i].res;
        assign res[i].credit_ret = pop[i];
    end

    // same lane order as the dispatcher restores program order
    assign out_valid_o  = (count[rr_ptr] != '0) && (out_cnt != '0);
    assign out_result_o = mem[rr_ptr][rd_ptr[rr_ptr]];

    always_comb begin
        for (int l = 0; l < LANE_NUM; l++) begin
            pop[l] = out_valid_o && (rr_ptr == LW'(l));
        end
    end

    always_ff @(posedge clk) begin
        for (int l = 0; l < LANE_NUM; l++) begin
            if (push[l]) begin
                mem[l][wr_ptr[l]] <= push_data[l];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int l = 0; l < LANE_NUM; l++) begin
            if (rst_i) begin
                wr_ptr[l] <= '0;
                rd_ptr[l] <= '0;
                count[l]  <= '0;
            end else begin
                if (push[l]) begin
                    wr_ptr[l] <= (wr_ptr[l] == PW'(LANE_FIFO_DEPTH - 1)) ? '0 : wr_ptr[l] + 1'b1;
                end
                if (pop[l]) begin
                    rd_ptr[l] <= (rd_ptr[l] == PW'(LANE_FIFO_DEPTH - 1)) ? '0 : rd_ptr[l] + 1'b1;
                end
                count[l] <= count[l] + CW'(push[l]) - CW'(pop[l]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            rr_ptr  <= '0;
            out_cnt <= OW'(OUT_CREDITS);
        end else begin
            if (out_valid_o) begin
                rr_ptr <= (rr_ptr == LW'(LANE_NUM - 1)) ? '0 : rr_ptr + 1'b1;
            end
            // spend one per result sent, regain one per returned credit
            out_cnt <= out_cnt - OW'(out_valid_o) + OW'(out_credit_i);
        end
    end

endmodule

//--- rtl/decode_stage_top.sv
`timescale 1ns/1ps

module decode_stage_top import decode_pkg::*; #(
    parameter int LANE_NUM        = 2,
    parameter int LANE_FIFO_DEPTH = 2,
    parameter int IN_DEPTH        = 4,
    parameter int OUT_CREDITS     = 4
) (
    input  logic        clk,
    input  logic        rst_i,
    input  logic        in_valid_i,
    input  logic [31:0] in_instr_i,
    input  logic [31:0] in_pc_i,
    input  logic        out_credit_i,
    output logic        in_credit_o,
    output logic        out_valid_o,
    output logic [31:0] out_pc_o,
    output logic        out_decode_valid_o,
    output logic [3:0]  out_aluop_o,
    output logic [2:0]  out_alusel_o,
    output logic        out_use_imm_o,
    output logic [31:0] out_imm_o,
    output logic        out_reg_read_o,
    output logic [4:0]  out_rj_o,
    output logic        out_reg_write_o,
    output logic [4:0]  out_rd_o,
    output logic        out_mem_load_o,
    output logic        out_mem_store_o
);

    logic [LANE_NUM-1:0]       lane_valid;
    logic [LANE_NUM-1:0][31:0] lane_instr;
    logic [LANE_NUM-1:0][31:0] lane_pc;
    decode_result_t            out_result;

    decode_if lane_if [LANE_NUM] ();

    instr_dispatcher #(
        .LANE_NUM        (LANE_NUM),
        .LANE_FIFO_DEPTH (LANE_FIFO_DEPTH),
        .IN_DEPTH        (IN_DEPTH)
    ) u_dispatcher (
        .clk          (clk),
        .rst_i        (rst_i),
        .in_valid_i   (in_valid_i),
        .in_instr_i   (in_instr_i),
        .in_pc_i      (in_pc_i),
        .in_credit_o  (in_credit_o),
        .lane_valid_o (lane_valid),
        .lane_instr_o (lane_instr),
        .lane_pc_o    (lane_pc),
        .crd          (lane_if)
    );

    for (genvar g = 0; g < LANE_NUM; g++) begin : g_lane
        decode_lane u_lane (
            .clk     (clk),
            .rst_i   (rst_i),
            .valid_i (lane_valid[g]),
            .instr_i (lane_instr[g]),
            .pc_i    (lane_pc[g]),
            .res     (lane_if[g])
        );
    end

    decode_collector #(
        .LANE_NUM        (LANE_NUM),
        .LANE_FIFO_DEPTH (LANE_FIFO_DEPTH),
        .OUT_CREDITS     (OUT_CREDITS)
    ) u_collector (
        .clk          (clk),
        .rst_i        (rst_i),
        .res          (lane_if),
        .out_credit_i (out_credit_i),
        .out_valid_o  (out_valid_o),
        .out_result_o (out_result)
    );

    // flatten the result record onto the top-level ports
    assign out_pc_o           = out_result.pc;
    assign out_decode_valid_o = out_result.valid;
    assign out_aluop_o        = out_result.aluop;
    assign out_alusel_o       = out_result.alusel;
    assign out_use_imm_o      = out_result.use_imm;
    assign out_imm_o          = out_result.imm;
    assign out_reg_read_o     = out_result.reg_read_valid;
    assign out_rj_o           = out_result.rj;
    assign out_reg_write_o    = out_result.reg_write_valid;
    assign out_rd_o           = out_result.rd;
    assign out_mem_load_o     = out_result.mem_load;
    assign out_mem_store_o    = out_result.mem_store;

endmodule

//--- testbench/decode_stage_checker.sv
`timescale 1ns/1ps

// credit counter checks, one instance per counter
module decode_stage_checker #(
    parameter int W   = 4,
    parameter int MAX = 4
) (
    input  logic         clk,
    input  logic         rst_i,
    input  logic         spend_i,
    input  logic [W-1:0] cnt_i
);

    // a send needs a credit in hand
    spend_needs_credit: assert property (
        @(posedge clk) disable iff (rst_i) spend_i |-> (cnt_i != '0)
    ) else $error("credit spent while the counter is zero");

    // returned credits never push the count past its start value
    count_in_range: assert property (
        @(posedge clk) disable iff (rst_i) cnt_i <= W'(MAX)
    ) else $error("credit counter above its initial value");

endmodule

// output credits of the collector
bind decode_collector decode_stage_checker #(
    .W   ($bits(out_cnt)),
    .MAX (OUT_CREDITS)
) u_out_credit_chk (
    .clk     (clk),
    .rst_i   (rst_i),
    .spend_i (out_valid_o),
    .cnt_i   (out_cnt)
);

// per-lane credits of the dispatcher, default two lanes
bind instr_dispatcher decode_stage_checker #(
    .W   ($bits(lane_cnt[0])),
    .MAX (LANE_FIFO_DEPTH)
) u_lane0_credit_chk (
    .clk     (clk),
    .rst_i   (rst_i),
    .spend_i (lane_valid_o[0]),
    .cnt_i   (lane_cnt[0])
);

bind instr_dispatcher decode_stage_checker #(
    .W   ($bits(lane_cnt[1])),
    .MAX (LANE_FIFO_DEPTH)
) u_lane1_credit_chk (
    .clk     (clk),
    .rst_i   (rst_i),
    .spend_i (lane_valid_o[1]),
    .cnt_i   (lane_cnt[1])
);

//--- testbench/decode_stage_tb.sv
`timescale 1ns/1ps
`include "decode_opcodes.svh"

module decode_stage_tb import decode_pkg::*; ();

    localparam int ROWS           = 24;
    localparam int IN_DEPTH       = 4;
    localparam int OUT_CREDITS    = 4;
    localparam int HOLD_CYCLES    = 40;
    localparam int TIMEOUT_CYCLES = ROWS * 20 + 200;
    localparam logic [31:0] PC_BASE = 32'h1c00_0000;

    logic        clk;
    logic        rst_i;
    logic        in_valid_i;
    logic [31:0] in_instr_i;
    logic [31:0] in_pc_i;
    logic        out_credit_i;
    logic        in_credit_o;
    logic        out_valid_o;
    logic [31:0] out_pc_o;
    logic        out_decode_valid_o;
    logic [3:0]  out_aluop_o;
    logic [2:0]  out_alusel_o;
    logic        out_use_imm_o;
    logic [31:0] out_imm_o;
    logic        out_reg_read_o;
    logic [4:0]  out_rj_o;
    logic        out_reg_write_o;
    logic [4:0]  out_rd_o;
    logic        out_mem_load_o;
    logic        out_mem_store_o;

    logic [31:0]    instr_tab [ROWS];
    decode_result_t exp_tab [ROWS];
    int             row_n = 0;
    int             next_row = 0;
    int             out_idx = 0;
    int             in_credits = IN_DEPTH;
    int             credit_pulses = 0;
    int             granted = 0;
    int             pending = 0;
    int             run_cycle = 0;
    int             cycle_cnt = 0;
    integer         seed = 32'h89c8a272;
    logic [31:0]    rnd;

    decode_stage_top #(
        .LANE_NUM        (2),
        .LANE_FIFO_DEPTH (2),
        .IN_DEPTH        (IN_DEPTH),
        .OUT_CREDITS     (OUT_CREDITS)
    ) u_decode_stage_top (
        .clk                (clk),
        .rst_i              (rst_i),
        .in_valid_i         (in_valid_i),
        .in_instr_i         (in_instr_i),
        .in_pc_i            (in_pc_i),
        .out_credit_i       (out_credit_i),
        .in_credit_o        (in_credit_o),
        .out_valid_o        (out_valid_o),
        .out_pc_o           (out_pc_o),
        .out_decode_valid_o (out_decode_valid_o),
        .out_aluop_o        (out_aluop_o),
        .out_alusel_o       (out_alusel_o),
        .out_use_imm_o      (out_use_imm_o),
        .out_imm_o          (out_imm_o),
        .out_reg_read_o     (out_reg_read_o),
        .out_rj_o           (out_rj_o),
        .out_reg_write_o    (out_reg_write_o),
        .out_rd_o           (out_rd_o),
        .out_mem_load_o     (out_mem_load_o),
        .out_mem_store_o    (out_mem_store_o)
    );

    always #4 clk = ~clk;

    task automatic fail_run(input string line);
        $display("%s", line);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            fail_run($sformatf("timeout after %0d cycles, %0d of %0d results arrived",
                               cycle_cnt, out_idx, ROWS));
        end
    end

    function automatic logic [31:0] ri20(input logic [6:0] op, input logic [19:0] imm,
                                         input logic [4:0] rd);
        return {op, imm, rd};
    endfunction

    function automatic logic [31:0] ri12(input logic [9:0] op, input logic [11:0] imm,
                                         input logic [4:0] rj, input logic [4:0] rd);
        return {op, imm, rj, rd};
    endfunction

    // one table row, pc follows the row number
    task automatic add_row(input logic [31:0] instr, input logic v, input aluop_e op,
                           input alusel_e sel, input logic [31:0] imm, input logic rr,
                           input logic [4:0] rj, input logic rw, input logic [4:0] rd,
                           input logic ld, input logic st);
        decode_result_t e;
        e                 = '0;
        e.valid           = v;
        e.pc              = PC_BASE + 32'(4 * row_n);
        e.aluop           = op;
        e.alusel          = sel;
        e.use_imm         = v;
        e.imm             = imm;
        e.reg_read_valid  = rr;
        e.rj              = rj;
        e.reg_write_valid = rw;
        e.rd              = rd;
        e.mem_load        = ld;
        e.mem_store       = st;
        instr_tab[row_n]  = instr;
        exp_tab[row_n]    = e;
        row_n++;
    endtask

    task automatic build_table();
        // 1ri20 moves
        add_row(ri20(`EXE_LU12I_W, 20'h12345, 5'd4),
                1'b1, ALU_LUI, SEL_MOVE, 32'h1234_5000, 1'b0, 5'd0, 1'b1, 5'd4, 1'b0, 1'b0);
        add_row(ri20(`EXE_PCADDI, 20'h00010, 5'd5),
                1'b1, ALU_PCADD, SEL_MOVE, 32'h0000_0040, 1'b0, 5'd0, 1'b1, 5'd5, 1'b0, 1'b0);
        add_row(ri20(`EXE_PCADDI, 20'hfffff, 5'd6),
                1'b1, ALU_PCADD, SEL_MOVE, 32'hffff_fffc, 1'b0, 5'd0, 1'b1, 5'd6, 1'b0, 1'b0);
        add_row(ri20(`EXE_PCADDI, 20'h80000, 5'd7),
                1'b1, ALU_PCADD, SEL_MOVE, 32'hffe0_0000, 1'b0, 5'd0, 1'b1, 5'd7, 1'b0, 1'b0);
        add_row(ri20(`EXE_PCADDU12I, 20'habcde, 5'd8),
                1'b1, ALU_PCADD, SEL_MOVE, 32'habcd_e000, 1'b0, 5'd0, 1'b1, 5'd8, 1'b0, 1'b0);
        // 2ri12 alu group
        add_row(ri12(`EXE_ADDI_W, 12'h7ff, 5'd1, 5'd2),
                1'b1, ALU_ADD, SEL_ARITH, 32'h0000_07ff, 1'b1, 5'd1, 1'b1, 5'd2, 1'b0, 1'b0);
        add_row(ri12(`EXE_ADDI_W, 12'h800, 5'd3, 5'd9),
                1'b1, ALU_ADD, SEL_ARITH, 32'hffff_f800, 1'b1, 5'd3, 1'b1, 5'd9, 1'b0, 1'b0);
        add_row(ri12(`EXE_SLTI, 12'hfff, 5'd10, 5'd11),
                1'b1, ALU_SLT, SEL_ARITH, 32'hffff_ffff, 1'b1, 5'd10, 1'b1, 5'd11, 1'b0, 1'b0);
        add_row(ri12(`EXE_SLTUI, 12'h900, 5'd12, 5'd13),
                1'b1, ALU_SLTU, SEL_ARITH, 32'hffff_f900, 1'b1, 5'd12, 1'b1, 5'd13, 1'b0, 1'b0);
        add_row(ri12(`EXE_ANDI, 12'hfff, 5'd14, 5'd15),
                1'b1, ALU_AND, SEL_LOGIC, 32'h0000_0fff, 1'b1, 5'd14, 1'b1, 5'd15, 1'b0, 1'b0);
        add_row(ri12(`EXE_ORI, 12'h800, 5'd16, 5'd17),
                1'b1, ALU_OR, SEL_LOGIC, 32'h0000_0800, 1'b1, 5'd16, 1'b1, 5'd17, 1'b0, 1'b0);
        add_row(ri12(`EXE_XORI, 12'h123, 5'd18, 5'd19),
                1'b1, ALU_XOR, SEL_LOGIC, 32'h0000_0123, 1'b1, 5'd18, 1'b1, 5'd19, 1'b0, 1'b0);
        // load and store, st.w keeps rd as the data register
        add_row(ri12(`EXE_LD_W, 12'hffc, 5'd3, 5'd20),
                1'b1, ALU_ADD, SEL_MEM, 32'hffff_fffc, 1'b1, 5'd3, 1'b1, 5'd20, 1'b1, 1'b0);
        add_row(ri12(`EXE_ST_W, 12'h010, 5'd3, 5'd21),
                1'b1, ALU_ADD, SEL_MEM, 32'h0000_0010, 1'b1, 5'd3, 1'b0, 5'd21, 1'b0, 1'b1);
        // illegal words
        add_row(32'hffff_ffff,
                1'b0, ALU_NOP, SEL_NOP, 32'h0, 1'b0, 5'd0, 1'b0, 5'd0, 1'b0, 1'b0);
        add_row(32'h0000_0000,
                1'b0, ALU_NOP, SEL_NOP, 32'h0, 1'b0, 5'd0, 1'b0, 5'd0, 1'b0, 1'b0);
        add_row(ri12(`EXE_ORI, 12'habc, 5'd31, 5'd0),
                1'b1, ALU_OR, SEL_LOGIC, 32'h0000_0abc, 1'b1, 5'd31, 1'b1, 5'd0, 1'b0, 1'b0);
        add_row(ri20(`EXE_LU12I_W, 20'hfffff, 5'd31),
                1'b1, ALU_LUI, SEL_MOVE, 32'hffff_f000, 1'b0, 5'd0, 1'b1, 5'd31, 1'b0, 1'b0);
        add_row(ri12(`EXE_LD_W, 12'h7f8, 5'd29, 5'd30),
                1'b1, ALU_ADD, SEL_MEM, 32'h0000_07f8, 1'b1, 5'd29, 1'b1, 5'd30, 1'b1, 1'b0);
        add_row(ri12(`EXE_ST_W, 12'h800, 5'd2, 5'd1),
                1'b1, ALU_ADD, SEL_MEM, 32'hffff_f800, 1'b1, 5'd2, 1'b0, 5'd1, 1'b0, 1'b1);
        // gap in the alu immediate opcode space
        add_row(ri12(10'b0000001011, 12'h055, 5'd1, 5'd2),
                1'b0, ALU_NOP, SEL_NOP, 32'h0, 1'b0, 5'd0, 1'b0, 5'd0, 1'b0, 1'b0);
        add_row(ri12(`EXE_SLTI, 12'h001, 5'd0, 5'd1),
                1'b1, ALU_SLT, SEL_ARITH, 32'h0000_0001, 1'b1, 5'd0, 1'b1, 5'd1, 1'b0, 1'b0);
        add_row(ri12(`EXE_XORI, 12'hf00, 5'd5, 5'd6),
                1'b1, ALU_XOR, SEL_LOGIC, 32'h0000_0f00, 1'b1, 5'd5, 1'b1, 5'd6, 1'b0, 1'b0);
        add_row(ri20(`EXE_PCADDU12I, 20'h00001, 5'd3),
                1'b1, ALU_PCADD, SEL_MOVE, 32'h0000_1000, 1'b0, 5'd0, 1'b1, 5'd3, 1'b0, 1'b0);
    endtask

    // send while an input credit is held, return output credits after the hold
    task automatic drive_cycle();
        in_valid_i   = 1'b0;
        out_credit_i = 1'b0;
        if (next_row < ROWS && in_credits > 0) begin
            in_valid_i = 1'b1;
            in_instr_i = instr_tab[next_row];
            in_pc_i    = PC_BASE + 32'(4 * next_row);
            in_credits--;
            next_row++;
        end
        rnd = $random(seed);
        if (run_cycle >= HOLD_CYCLES && pending > 0 && rnd[0]) begin
            out_credit_i = 1'b1;
            pending--;
        end
    endtask

    task automatic sample_cycle();
        decode_result_t got;
        if (in_credit_o) begin
            in_credits++;
            credit_pulses++;
            assert (in_credits <= IN_DEPTH) else
                fail_run($sformatf("FAIL at %0t: input credits above %0d", $time, IN_DEPTH));
        end
        if (out_valid_o) begin
            assert (out_idx < ROWS) else
                fail_run($sformatf("FAIL at %0t: extra result with pc %h", $time, out_pc_o));
            // sends are bounded by the initial pool plus what was returned
            assert (out_idx < OUT_CREDITS + granted) else
                fail_run($sformatf("FAIL at %0t: result %0d sent with %0d credits granted",
                                   $time, out_idx, OUT_CREDITS + granted));
            got.valid           = out_decode_valid_o;
            got.pc              = out_pc_o;
            got.aluop           = aluop_e'(out_aluop_o);
            got.alusel          = alusel_e'(out_alusel_o);
            got.use_imm         = out_use_imm_o;
            got.imm             = out_imm_o;
            got.reg_read_valid  = out_reg_read_o;
            got.rj              = out_rj_o;
            got.reg_write_valid = out_reg_write_o;
            got.rd              = out_rd_o;
            got.mem_load        = out_mem_load_o;
            got.mem_store       = out_mem_store_o;
            assert (got === exp_tab[out_idx]) else
                fail_run($sformatf("FAIL at %0t: row %0d got %h expected %h",
                                   $time, out_idx, got, exp_tab[out_idx]));
            out_idx++;
            pending++;
        end
        if (out_credit_i) begin
            granted++;
        end
    endtask

    task automatic step_cycle();
        drive_cycle();
        @(negedge clk);
        sample_cycle();
        @(posedge clk);
        #1;
        run_cycle++;
    endtask

    initial begin
        clk          = 1'b0;
        rst_i        = 1'b1;
        in_valid_i   = 1'b0;
        in_instr_i   = '0;
        in_pc_i      = '0;
        out_credit_i = 1'b0;
        build_table();
        repeat (8) @(posedge clk);
        #1;
        rst_i = 1'b0;
        while (out_idx < ROWS) begin
            step_cycle();
        end
        // drain window, nothing more may come out
        repeat (12) begin
            step_cycle();
        end
        assert (credit_pulses == ROWS) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            fail_run($sformatf("FAIL at %0t: %0d input credit pulses for %0d instructions",
                               $time, credit_pulses, ROWS));
        end
    end

endmodule

//--- src.f
+incdir+include
rtl/decode_pkg.sv
rtl/decode_if.sv
rtl/decoder_1ri20.sv
rtl/decoder_2ri12.sv
rtl/decode_lane.sv
rtl/instr_dispatcher.sv
rtl/decode_collector.sv
rtl/decode_stage_top.sv
testbench/decode_stage_checker.sv
testbench/decode_stage_tb.sv

//--- run.sh
#!/bin/sh
# build the decode stage testbench with Verilator and run it
# the exit status of the simulation binary is the test result
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f src.f \
    --top-module decode_stage_tb \
    -o decode_stage_sim

./obj_dir/decode_stage_sim
